/* cart_loader_settings.svh */
// Shared constants for the cartridge load front end
// Include wherever header addresses or bus widths are needed
// All header addresses are byte addresses on the host load bus

`ifndef CART_LOADER_SETTINGS_SVH
`define CART_LOADER_SETTINGS_SVH

// Host load bus widths
`define CL_ADDR_W             25
`define CL_DATA_W             16
`define CL_INDEX_W            8

// Region field of the cartridge header
`define CL_HDR_REGION0        25'h1F0
`define CL_HDR_REGION1        25'h1F2
`define CL_HDR_END            25'h200     // First word past the header

// Serial number words and the lookup trigger
`define CL_ID_FIRST           25'h182
`define CL_ID_LAST            25'h18A
`define CL_ID_MATCH           25'h18C

`define CL_GUN_DELAY_DEFAULT  8'd44       // Sensor delay for unlisted carts

`endif

/* cart_bus_pkg.sv */
// Vector types of the host load bus and the image size
// Import wherever the load bus or the recorded size is handled

`default_nettype none

`include "cart_loader_settings.svh"

package cart_bus_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Host side

	// Byte address of the current word, bit 0 always clear
	typedef logic [`CL_ADDR_W-1:0] load_addr_t;

	// One image word as it comes from the host
	typedef logic [`CL_DATA_W-1:0] load_word_t;

	typedef logic [`CL_INDEX_W-1:0] file_index_t;   // Host file slot and extension code

	////////////////////////////////////////////////////////////////////////////
	// Memory side

	// Image length in bytes, taken from the last load address
	typedef logic [`CL_ADDR_W-1:0] rom_size_t;

endpackage

`default_nettype wire

/* cart_info_pkg.sv */
// Types that describe a loaded cartridge and the user region options
// Region codes follow the console status encoding
// Quirk bit 0 is sram, then eeprom, noram, fifo, pier, svp and fmbusy at bit 6

`default_nettype none

package cart_info_pkg;

	typedef enum logic [1:0] {
		JAPAN  = 2'd0,
		USA    = 2'd1,
		EUROPE = 2'd2
	} region_t;

	// Search order for header flags, first entry also the fallback
	typedef enum logic [1:0] {
		US_EU_JP = 2'd0,
		EU_US_JP = 2'd1,
		US_JP_EU = 2'd2,
		JP_US_EU = 2'd3
	} region_prio_t;

	typedef enum logic [1:0] {
		HEADER   = 2'd0,   // Region letters in the header
		FILE_EXT = 2'd1,   // Index bits from the file extension
		DISABLED = 2'd2
	} auto_region_t;

	typedef logic [63:0] cart_serial_t;   // Eight ASCII characters, first in top byte
	typedef logic [6:0]  quirk_vec_t;
	typedef logic [7:0]  gun_delay_t;

endpackage

`default_nettype wire

/* cart_load_if.sv */
// Host load bus shared by the loader blocks
// The top level drives it and every other block only listens
// A write is a single cycle wr pulse while active is high

`default_nettype none

interface cart_load_if
	import cart_bus_pkg::*;
();

	logic        active;   // Cartridge download in progress
	logic        wr;       // Word strobe
	load_addr_t  addr;
	load_word_t  data;
	file_index_t index;

	// Top level side
	modport host (
		output active,
		output wr,
		output addr,
		output data,
		output index
	);

	// Decoders and the ROM writer
	modport listen (
		input active,
		input wr,
		input addr,
		input data,
		input index
	);

endinterface

`default_nettype wire

/* rom_write_ctrl.sv */
// Forwards host words to both ROM memories by a toggle request
// Holds the host with load_wait until both memories have taken the word
// Records the image size when the download ends

`default_nettype none

module rom_write_ctrl
	import cart_bus_pkg::*;
(
	input  logic        clk_sys,
	input  logic        RESET,
	cart_load_if.listen ld,
	input  logic        sdr_wr_ack,
	input  logic        ddr_wr_ack,
	output logic        rom_wr,
	output logic        load_wait,
	output rom_size_t   rom_size
);

	logic active_d;
	logic wr_take;
	logic both_done;

	assign wr_take   = ld.active & ld.wr;
	assign both_done = (sdr_wr_ack == rom_wr) && (ddr_wr_ack == rom_wr);

	// Request toggle and host stall
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_wr    <= 1'b0;
			load_wait <= 1'b0;
			active_d  <= 1'b0;
		end else begin
			active_d <= ld.active;
			if (wr_take) begin
				rom_wr    <= ~rom_wr;    // New request to both memories
				load_wait <= 1'b1;
			end else if (load_wait && both_done) begin
				load_wait <= 1'b0;
			end
		end
	end

	// End of download leaves the last address on the bus
	always_ff @(posedge clk_sys) begin
		if (active_d && !ld.active)
			rom_size <= ld.addr;
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks

	// Host respects the stall
	a_no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (RESET)
		load_wait |-> !ld.wr);

	// Stall ends with both memories caught up
	a_wait_release: assert property (@(posedge clk_sys) disable iff (RESET)
		$fell(load_wait) |-> sdr_wr_ack == rom_wr && ddr_wr_ack == rom_wr);

endmodule

`default_nettype wire

/* header_region_decode.sv */
// Decodes the region field of the cartridge header into J, U and E flags
// Flags build up over a download and clear when the next one starts
// hdr_ready tells the region chooser that the header has gone by

`default_nettype none

`include "cart_loader_settings.svh"

module header_region_decode (
	input  logic        clk_sys,
	input  logic        RESET,
	cart_load_if.listen ld,
	output logic        hdr_j,
	output logic        hdr_u,
	output logic        hdr_e,
	output logic        hdr_ready
);

	logic [2:0] flags;        // {E, U, J}
	logic [2:0] flags_next;
	logic       active_d;
	logic       hdr_wr;
	logic [3:0] hex_mask;     // A to F folded onto the digit mask
	logic [7:0] lo_char;

	// One flag per accepted letter
	function automatic logic [2:0] letter_flags(input logic [7:0] c);
		logic [2:0] f;
		case (c)
			"J":     f = 3'b001;
			"U":     f = 3'b010;
			"E":     f = 3'b100;
			default: f = 3'b000;
		endcase
		return f;
	endfunction

	assign hdr_wr   = ld.active & ld.wr;
	assign lo_char  = ld.data[7:0];
	assign hex_mask = ld.data[3:0] - 4'd7;

	always_comb begin
		flags_next = (ld.active && !active_d) ? 3'b000 : flags;

		if (hdr_wr && ld.addr == `CL_HDR_REGION0) begin
			if (letter_flags(lo_char) != 3'b000)
				flags_next = flags_next | letter_flags(lo_char);
			else if (lo_char >= "0" && lo_char <= "9")
				flags_next = {ld.data[3], ld.data[2], ld.data[0]};
			else if (lo_char >= "A" && lo_char <= "F")
				flags_next = {hex_mask[3], hex_mask[2], hex_mask[0]};

			// Second character of the field, letters only
			flags_next = flags_next | letter_flags(ld.data[15:8]);
		end

		if (hdr_wr && ld.addr == `CL_HDR_REGION1)
			flags_next = flags_next | letter_flags(lo_char);
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			flags     <= 3'b000;
			hdr_ready <= 1'b0;
			active_d  <= 1'b0;
		end else begin
			active_d <= ld.active;
			flags    <= flags_next;
			if (active_d && !ld.active)
				hdr_ready <= 1'b0;    // Download over
			else if (hdr_wr && ld.addr == `CL_HDR_END)
				hdr_ready <= 1'b1;
		end
	end

	assign {hdr_e, hdr_u, hdr_j} = flags;

endmodule

`default_nettype wire

/* cart_id_quirks.sv */
// Collects the cartridge serial number from the header words
// and looks it up in the compatibility fix and light gun tables
// The lookup runs on the header word that follows the serial

`default_nettype none

`include "cart_loader_settings.svh"

module cart_id_quirks
	import cart_info_pkg::*;
(
	input  logic        clk_sys,
	input  logic        RESET,
	cart_load_if.listen ld,
	output quirk_vec_t  quirks,
	output logic        gun_type,
	output gun_delay_t  gun_delay
);

	// Bit positions in the quirk vector
	localparam int Q_SRAM   = 0;
	localparam int Q_EEPROM = 1;
	localparam int Q_NORAM  = 2;
	localparam int Q_FIFO   = 3;
	localparam int Q_PIER   = 4;
	localparam int Q_SVP    = 5;
	localparam int Q_FMBUSY = 6;

	cart_serial_t serial;
	logic         active_d;
	logic         id_wr;
	logic [15:0]  swapped;   // Header text is big endian

	function automatic quirk_vec_t quirk_lookup(input cart_serial_t s);
		quirk_vec_t q;
		q = '0;
		case (s)
			"T-081276": q[Q_SRAM]   = 1'b1;
			"MK-1215 ": q[Q_EEPROM] = 1'b1;
			"T-113016": q[Q_NORAM]  = 1'b1;   // Fake RAM check
			"T-89016 ": q[Q_FIFO]   = 1'b1;
			"T-574023": q[Q_PIER]   = 1'b1;
			"MK-1229 ": q[Q_SVP]    = 1'b1;
			"T-35036 ": q[Q_FMBUSY] = 1'b1;
			default:    q = '0;
		endcase
		return q;
	endfunction

	assign id_wr   = ld.active & ld.wr;
	assign swapped = {ld.data[7:0], ld.data[15:8]};

	// Serial characters in header order
	always_ff @(posedge clk_sys) begin
		if (id_wr) begin
			if (ld.addr == `CL_ID_FIRST)        serial[63:56] <= ld.data[15:8];
			if (ld.addr == `CL_ID_FIRST + 25'd2) serial[55:40] <= swapped;
			if (ld.addr == `CL_ID_FIRST + 25'd4) serial[39:24] <= swapped;
			if (ld.addr == `CL_ID_FIRST + 25'd6) serial[23:8]  <= swapped;
			if (ld.addr == `CL_ID_LAST)         serial[7:0]   <= ld.data[7:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			quirks    <= '0;
			gun_type  <= 1'b0;
			gun_delay <= `CL_GUN_DELAY_DEFAULT;
			active_d  <= 1'b0;
		end else begin
			active_d <= ld.active;
			if (ld.active && !active_d)
				quirks <= '0;    // New cart
			if (id_wr && ld.addr == `CL_ID_MATCH) begin
				quirks <= quirks | quirk_lookup(serial);
				case (serial)
					"T-95096-": begin
						gun_type  <= 1'b1;
						gun_delay <= 8'd52;
					end
					"MK-1533 ": begin
						gun_type  <= 1'b0;
						gun_delay <= 8'd100;
					end
					default: begin
						gun_type  <= 1'b0;
						gun_delay <= `CL_GUN_DELAY_DEFAULT;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* region_select.sv */
// Chooses a console region once the header has been seen
// Source is the header flags, the file index or nothing, set by mode
// region_set asks the system to apply region_req until the download ends

`default_nettype none

module region_select
	import cart_info_pkg::*;
(
	input  logic         clk_sys,
	input  logic         RESET,
	cart_load_if.listen  ld,
	input  logic         hdr_j,
	input  logic         hdr_u,
	input  logic         hdr_e,
	input  logic         hdr_ready,
	input  auto_region_t mode,
	input  region_prio_t prio,
	output region_t      region_req,
	output logic         region_set
);

	logic [1:0] ready_q;   // Registered hdr_ready, newest in bit 0
	logic       ready_rise;
	logic       ready_fall;

	// First present region in the order that p names
	function automatic region_t pick_region(input region_prio_t p, input logic [2:0] f);
		region_t order [3];
		region_t pick;
		case (p)
			US_EU_JP: order = '{USA, EUROPE, JAPAN};
			EU_US_JP: order = '{EUROPE, USA, JAPAN};
			US_JP_EU: order = '{USA, JAPAN, EUROPE};
			default:  order = '{JAPAN, USA, EUROPE};
		endcase
		pick = order[0];    // Also the answer with no flags
		for (int i = 2; i >= 0; i--) begin
			if (f[order[i]])
				pick = order[i];
		end
		return pick;
	endfunction

	assign ready_rise = ready_q[0] & ~ready_q[1];
	assign ready_fall = ~ready_q[0] & ready_q[1];

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ready_q    <= 2'b00;
			region_set <= 1'b0;
		end else begin
			ready_q <= {ready_q[0], hdr_ready};
			if (ready_rise && mode == HEADER) begin
				region_set <= 1'b1;
				region_req <= pick_region(prio, {hdr_e, hdr_u, hdr_j});
			end else if (ready_rise && mode == FILE_EXT) begin
				region_set <= |ld.index;
				region_req <= region_t'(ld.index[7:6]);
			end else if (ready_fall) begin
				region_set <= 1'b0;
			end
		end
	end

	// Code 3 has no region behind it
	a_req_valid: assert property (@(posedge clk_sys) disable iff (RESET)
		region_set |-> region_req inside {JAPAN, USA, EUROPE});

endmodule

`default_nettype wire

/* cart_loader_top.sv */
// Cartridge load front end of the console core
// Takes the host download bus as plain ports and puts it on the load bus
// The dl_* strobe and level carry cartridge downloads only

`default_nettype none

module cart_loader_top
	import cart_bus_pkg::*;
	import cart_info_pkg::*;
(
	input  logic         clk_sys,
	input  logic         RESET,
	input  logic         dl_active,
	input  logic         dl_wr,
	input  load_addr_t   dl_addr,
	input  load_word_t   dl_data,
	input  file_index_t  dl_index,
	input  auto_region_t auto_region_mode,
	input  region_prio_t region_priority,
	input  logic         sdr_wr_ack,
	input  logic         ddr_wr_ack,
	output logic         rom_wr,
	output logic         load_wait,
	output rom_size_t    rom_size,
	output region_t      region_req,
	output logic         region_set,
	output quirk_vec_t   quirks,
	output logic         gun_type,
	output gun_delay_t   gun_delay
);

	logic hdr_j, hdr_u, hdr_e, hdr_ready;

	cart_load_if ld ();

	assign ld.active = dl_active;
	assign ld.wr     = dl_wr;
	assign ld.addr   = dl_addr;
	assign ld.data   = dl_data;
	assign ld.index  = dl_index;

	rom_write_ctrl u_rom_write (
		.clk_sys, .RESET, .ld(ld.listen),
		.sdr_wr_ack, .ddr_wr_ack, .rom_wr, .load_wait, .rom_size
	);

	header_region_decode u_hdr_region (
		.clk_sys, .RESET, .ld(ld.listen), .hdr_j, .hdr_u, .hdr_e, .hdr_ready
	);

	cart_id_quirks u_id_quirks (
		.clk_sys, .RESET, .ld(ld.listen), .quirks, .gun_type, .gun_delay
	);

	region_select u_region_sel (
		.clk_sys, .RESET, .ld(ld.listen), .hdr_j, .hdr_u, .hdr_e, .hdr_ready,
		.mode(auto_region_mode), .prio(region_priority), .region_req, .region_set
	);

endmodule

`default_nettype wire

/* tb_cart_loader.sv */
// Testbench for the cartridge load front end
// Reads load records and expected results from cart_loader_stim.txt,
// models both ROM memories with random ack delays and checks every test

`default_nettype none

`include "cart_loader_settings.svh"

module tb_cart_loader
	import cart_bus_pkg::*;
	import cart_info_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int WAIT_LIMIT = 32;   // Cycles allowed for one memory write

	logic         clk_sys;
	logic         RESET;
	logic         dl_active;
	logic         dl_wr;
	load_addr_t   dl_addr;
	load_word_t   dl_data;
	file_index_t  dl_index;
	auto_region_t auto_region_mode;
	region_prio_t region_priority;
	logic         sdr_wr_ack = 1'b0;
	logic         ddr_wr_ack = 1'b0;
	logic         rom_wr;
	logic         load_wait;
	rom_size_t    rom_size;
	region_t      region_req;
	logic         region_set;
	quirk_vec_t   quirks;
	logic         gun_type;
	gun_delay_t   gun_delay;

	int         test_num = 0;
	int         test_errs = 0;
	int         total_errs = 0;
	int         failed_tests = 0;
	int         n_writes;
	load_addr_t last_addr;
	int         sdr_acks = 0;
	int         ddr_acks = 0;
	int         sdr_base;
	int         ddr_base;
	int         sdr_cnt;
	int         ddr_cnt;
	logic       run_aborted = 1'b0;
	logic [7:0] lfsr_state = 8'd57;

	cart_loader_top DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////////////////////
	// Memory model

	// Taps 8, 6, 5, 4
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_state[7] ^ lfsr_state[5] ^ lfsr_state[4] ^ lfsr_state[3];
		lfsr_state = {lfsr_state[6:0], fb};
		return fb;
	endfunction

	function automatic int ack_delay();
		int d;
		d = 1;
		for (int i = 0; i < 3; i++)
			d = d + (int'(lfsr_step()) << i);
		return d;   // 1 to 8
	endfunction

	// Each memory copies rom_wr onto its ack after its own delay
	always @(posedge clk_sys) begin
		if (RESET) begin
			sdr_wr_ack <= 1'b0;
			ddr_wr_ack <= 1'b0;
			sdr_cnt    <= 0;
			ddr_cnt    <= 0;
		end else begin
			if (sdr_cnt > 1)
				sdr_cnt <= sdr_cnt - 1;
			else if (sdr_cnt == 1) begin
				sdr_wr_ack <= rom_wr;
				sdr_acks   <= sdr_acks + 1;
				sdr_cnt    <= 0;
			end else if (sdr_wr_ack != rom_wr)
				sdr_cnt <= ack_delay();
			if (ddr_cnt > 1)
				ddr_cnt <= ddr_cnt - 1;
			else if (ddr_cnt == 1) begin
				ddr_wr_ack <= rom_wr;
				ddr_acks   <= ddr_acks + 1;
				ddr_cnt    <= 0;
			end else if (ddr_wr_ack != rom_wr)
				ddr_cnt <= ack_delay();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Host side tasks

	task automatic report_error(input string msg);
		$display("[ERROR] %0d ns: test %0d: %s", $time, test_num, msg);
		test_errs++;
		total_errs++;
	endtask

	task automatic start_test(input logic [1:0] m, input logic [1:0] p, input file_index_t idx);
		test_num++;
		test_errs = 0;
		n_writes  = 0;
		sdr_base  = sdr_acks;
		ddr_base  = ddr_acks;
		auto_region_mode <= auto_region_t'(m);
		region_priority  <= region_prio_t'(p);
		dl_index         <= idx;
		dl_active        <= 1'b1;
		repeat (2) @(posedge clk_sys);   // Flags and quirks clear first
	endtask

	task automatic write_word(input load_addr_t a, input load_word_t d);
		int t;
		dl_addr <= a;
		dl_data <= d;
		dl_wr   <= 1'b1;
		@(posedge clk_sys);
		dl_wr <= 1'b0;
		n_writes++;
		last_addr = a;
		@(posedge clk_sys);
		assert (load_wait)
			else report_error($sformatf("load_wait low after write to %h", a));
		t = 0;
		while (load_wait && t < WAIT_LIMIT) begin
			@(posedge clk_sys);
			t++;
		end
		if (load_wait) begin
			$display("Timeout in test %0d, memories never finished the write to %h",
				test_num, a);
			run_aborted = 1'b1;
		end else begin
			assert (sdr_wr_ack == rom_wr && ddr_wr_ack == rom_wr)
				else report_error("load_wait fell before both acks matched");
		end
	endtask

	task automatic end_test(input logic [1:0] exp_region, input logic exp_set,
		input quirk_vec_t exp_q, input logic exp_gun, input gun_delay_t exp_delay);
		repeat (2) @(posedge clk_sys);
		assert (region_set == exp_set)
			else report_error($sformatf("region_set %b, expected %b", region_set, exp_set));
		if (exp_set) begin
			assert (region_req == exp_region)
				else report_error($sformatf("region %0d, expected %0d", region_req, exp_region));
		end
		assert (quirks == exp_q)
			else report_error($sformatf("quirks %h, expected %h", quirks, exp_q));
		assert (gun_type == exp_gun && gun_delay == exp_delay)
			else report_error($sformatf("gun %b/%0d, expected %b/%0d",
				gun_type, gun_delay, exp_gun, exp_delay));
		assert (sdr_acks - sdr_base == n_writes && ddr_acks - ddr_base == n_writes)
			else report_error($sformatf("acks %0d/%0d for %0d writes",
				sdr_acks - sdr_base, ddr_acks - ddr_base, n_writes));
		dl_active <= 1'b0;
		repeat (4) @(posedge clk_sys);   // Size latch and region release
		assert (rom_size == last_addr)
			else report_error($sformatf("rom_size %h, expected %h", rom_size, last_addr));
		assert (!region_set)
			else report_error("region_set still high after the download");
		$display("Test %0d: %0d writes, %0d errors", test_num, n_writes, test_errs);
		if (test_errs != 0)
			failed_tests++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Record reader

	initial begin
		int               fd;
		int               code;
		logic [7:0]       kind;
		logic [31:0]      f1, f2, f3, f4, f5;
		logic [8*128-1:0] line;

		RESET            <= 1'b1;
		dl_active        <= 1'b0;
		dl_wr            <= 1'b0;
		dl_addr          <= '0;
		dl_data          <= '0;
		dl_index         <= '0;
		auto_region_mode <= HEADER;
		region_priority  <= US_EU_JP;
		repeat (10) @(posedge clk_sys);
		RESET <= 1'b0;
		repeat (2) @(posedge clk_sys);

		assert (!load_wait && !region_set && quirks == '0 && !gun_type && !rom_wr &&
			gun_delay == `CL_GUN_DELAY_DEFAULT)
			else report_error("outputs not at their reset values");

		fd = $fopen("cart_loader_stim.txt", "r");
		if (fd == 0) begin
			$display("Cannot open cart_loader_stim.txt, no tests run");
			run_aborted = 1'b1;
		end
		while (!run_aborted && $fscanf(fd, " %c", kind) == 1) begin
			case (kind)
				"#": code = $fgets(line, fd);   // Comment up to end of line
				"T": begin
					code = $fscanf(fd, "%h %h %h", f1, f2, f3);
					if (code == 3)
						start_test(f1[1:0], f2[1:0], f3[7:0]);
					else
						code = 0;
				end
				"W": begin
					code = $fscanf(fd, "%h %h", f1, f2);
					if (code == 2)
						write_word(f1[24:0], f2[15:0]);
					else
						code = 0;
				end
				"E": begin
					code = $fscanf(fd, "%h %h %h %h %h", f1, f2, f3, f4, f5);
					if (code == 5)
						end_test(f1[1:0], f2[0], f3[6:0], f4[0], f5[7:0]);
					else
						code = 0;
				end
				default: code = 0;
			endcase
			if (code <= 0) begin
				$display("Bad record starting with '%c' in the stimulus file", kind);
				run_aborted = 1'b1;
			end
		end
		if (fd != 0)
			$fclose(fd);

		$display("Tests run: %0d, failed tests: %0d, errors: %0d",
			test_num, failed_tests, total_errs);
		if (total_errs == 0 && !run_aborted && test_num > 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* cart_loader_stim.txt */
# Records: T mode prio index | W addr data | E region set quirks gun_type gun_delay
# All fields hex, a test runs from its T record to its E record
# Serial T-081276 with header letters U and E, then the other three priorities
T 0 0 00  W 182 5420  W 184 302D  W 186 3138  W 188 3732  W 18A 2036  W 18C 0000
W 1F0 4555  W 200 0000  E 1 1 01 0 2C
T 0 1 00  W 1F0 4555  W 200 0000  E 2 1 00 0 2C
T 0 2 00  W 1F0 4555  W 200 0000  E 1 1 00 0 2C
T 0 3 00  W 1F0 4555  W 200 0000  E 1 1 00 0 2C
# Hex digits 1, A and D, then a header without region marks
T 0 0 00  W 1F0 0031  W 200 0000  E 0 1 00 0 2C
T 0 2 00  W 1F0 0041  W 200 0000  E 2 1 00 0 2C
T 0 3 00  W 1F0 2044  W 200 0000  E 0 1 00 0 2C
T 0 1 00  W 1F0 2020  W 200 0000  E 2 1 00 0 2C
# File extension with index 41 and 00, then disabled mode with serial MK-1229
T 1 1 41  W 1F0 4555  W 200 0000  E 1 1 00 0 2C
T 1 0 00  W 1F0 4555  W 200 0000  E 0 0 00 0 2C
T 2 0 80  W 182 4D20  W 184 2D4B  W 186 3231  W 188 3932  W 18A 2020  W 18C 0000
W 1F0 4555  W 200 0000  E 0 0 20 0 2C
# Gun serials T-95096- and MK-1533, then the unknown serial T-95076-
T 0 0 00  W 182 5420  W 184 392D  W 186 3035  W 188 3639  W 18A 202D  W 18C 0000
E 0 0 00 1 34
T 0 0 00  W 182 4D20  W 184 2D4B  W 186 3531  W 188 3333  W 18A 2020  W 18C 0000
E 0 0 00 0 64
T 0 0 00  W 182 5420  W 184 392D  W 186 3035  W 188 3637  W 18A 202D  W 18C 0000
E 0 0 00 0 2C

/* cart_loader.f */
+incdir+.
cart_bus_pkg.sv
cart_info_pkg.sv
cart_load_if.sv
rom_write_ctrl.sv
header_region_decode.sv
cart_id_quirks.sv
region_select.sv
cart_loader_top.sv
tb_cart_loader.sv

/* Bender.yml */
package:
  name: cart_loader

sources:
  - include_dirs:
      - .
    files:
      - cart_bus_pkg.sv
      - cart_info_pkg.sv
      - cart_load_if.sv
      - rom_write_ctrl.sv
      - header_region_decode.sv
      - cart_id_quirks.sv
      - region_select.sv
      - cart_loader_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cart_loader.sv
